// ==== design/bp_fetch_pkg.sv ====
package bp_fetch_pkg;

  // address width of the fetch unit.
  localparam int xlen = 32;

  // one fetch cycle, presented to the predictor every cycle.
  typedef struct packed {
    logic [xlen-1:0] pc;
    // decode hints for the fetched instruction.
    logic            is_branch;
    logic            is_uncond;
    logic            is_return;
    // fetch held this cycle.
    logic            stall;
    // pipeline flush.
    logic            clear;
  } bp_lookup_t;

  // answer to a lookup in the same cycle.
  typedef struct packed {
    // predicted target from the target buffer.
    logic [xlen-1:0] target;
    logic            branch_hit;
    logic            uncond_hit;
    // counter decision from the history table.
    logic            taken;
    // top of the return stack.
    logic [xlen-1:0] ret_addr;
    logic            ret_valid;
  } bp_prediction_t;

endpackage

// ==== design/bp_history_table.sv ====
`timescale 1ns/1ps

module bp_history_table #(
  parameter int bht_depth = 8
) (
  input  logic                        clock,
  input  logic                        reset,
  input  bp_fetch_pkg::bp_lookup_t    lookup,
  input  bp_resolve_pkg::bp_resolve_t resolve,
  output logic                        taken
);
  import bp_resolve_pkg::*;

  localparam int entries = 2 ** bht_depth;

  ctr_t ctr_mem [entries] = '{default: ctr_min};

  // outcomes of the most recent resolved branches, newest in bit 0.
  logic [bht_depth-1:0] history;

  logic [bht_depth-1:0] lookup_index;
  logic [bht_depth-1:0] update_index;
  ctr_t                 lookup_ctr;
  ctr_t                 update_ctr;
  ctr_t                 next_ctr;
  logic                 suppress;

  // gshare: global history folded into the pc.
  assign lookup_index = history ^ lookup.pc[bht_depth:1];
  assign update_index = history ^ resolve.pc[bht_depth:1];

  // separate read ports for fetch and execute.
  assign lookup_ctr = ctr_mem[lookup_index];
  assign update_ctr = ctr_mem[update_index];

  assign suppress = lookup.stall | lookup.clear | resolve.taken;

  assign taken = lookup.is_branch & ~suppress & lookup_ctr[1];

  // saturate at both ends.
  always_comb begin
    next_ctr = update_ctr;
    if (resolve.taken) begin
      if (update_ctr != ctr_max) begin
        next_ctr = update_ctr + 2'd1;
      end
    end else begin
      if (update_ctr != ctr_min) begin
        next_ctr = update_ctr - 2'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      history <= '0;
    end else if (resolve.is_branch) begin
      history <= {history[bht_depth-2:0], resolve.taken};
    end
  end

  always_ff @(posedge clock) begin
    if (resolve.is_branch) begin
      ctr_mem[update_index] <= next_ctr;
    end
  end

endmodule

// ==== design/bp_resolve_pkg.sv ====
package bp_resolve_pkg;

  // 2-bit saturating counter state.
  typedef logic [1:0] ctr_t;

  // strongly taken and strongly not taken.
  localparam ctr_t ctr_max = 2'd3;
  localparam ctr_t ctr_min = 2'd0;

  // outcome of a control transfer from the execute stage.
  typedef struct packed {
    logic [bp_fetch_pkg::xlen-1:0] pc;
    logic [bp_fetch_pkg::xlen-1:0] target;
    // sequential address, pushed by a call.
    logic [bp_fetch_pkg::xlen-1:0] next_pc;
    logic                          is_branch;
    logic                          is_uncond;
    logic                          is_call;
    // taken also means fetch is redirected this cycle.
    logic                          taken;
  } bp_resolve_t;

endpackage

// ==== design/bp_return_stack.sv ====
`timescale 1ns/1ps

module bp_return_stack #(
  parameter int ras_depth = 3
) (
  input  logic                          clock,
  input  logic                          reset,
  input  bp_fetch_pkg::bp_lookup_t      lookup,
  input  bp_resolve_pkg::bp_resolve_t   resolve,
  output logic [bp_fetch_pkg::xlen-1:0] ret_addr,
  output logic                          ret_valid
);
  import bp_fetch_pkg::*;

  localparam int entries = 2 ** ras_depth;
  localparam logic [ras_depth:0] full_count = (ras_depth + 1)'(entries);

  logic [xlen-1:0] stack_mem [entries] = '{default: '0};

  // next free slot; the top is one below it.
  logic [ras_depth-1:0] write_ptr;
  logic [ras_depth-1:0] top_ptr;
  logic [ras_depth:0]   count;
  logic                 suppress;
  logic                 push;
  logic                 pop;

  assign top_ptr = write_ptr - 1'b1;

  assign suppress = lookup.stall | lookup.clear | resolve.taken;

  assign push = resolve.is_call;
  assign pop = lookup.is_return & ~suppress & (count != '0);

  assign ret_valid = pop;
  assign ret_addr = pop ? stack_mem[top_ptr] : '0;

  // a full stack wraps and loses its oldest entry.
  always_ff @(posedge clock) begin
    if (reset) begin
      write_ptr <= '0;
      count <= '0;
    end else if (push) begin
      write_ptr <= write_ptr + 1'b1;
      if (count != full_count) begin
        count <= count + 1'b1;
      end
    end else if (pop) begin
      write_ptr <= top_ptr;
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      stack_mem[write_ptr] <= resolve.next_pc;
    end
  end

endmodule

// ==== design/bp_target_buffer.sv ====
`timescale 1ns/1ps

module bp_target_buffer #(
  parameter int btb_depth = 6
) (
  input  logic                          clock,
  input  bp_fetch_pkg::bp_lookup_t      lookup,
  input  bp_resolve_pkg::bp_resolve_t   resolve,
  output logic [bp_fetch_pkg::xlen-1:0] target,
  output logic                          branch_hit,
  output logic                          uncond_hit
);
  import bp_fetch_pkg::*;

  localparam int tag_width = xlen - btb_depth - 1;
  localparam int entries = 2 ** btb_depth;

  // pc bits above the index, then the target.
  typedef struct packed {
    logic [tag_width-1:0] tag;
    logic [xlen-1:0]      target;
  } btb_entry_t;

  btb_entry_t entry_mem [entries] = '{default: '0};

  logic [btb_depth-1:0] read_index;
  logic [btb_depth-1:0] write_index;
  btb_entry_t           read_entry;
  btb_entry_t           write_entry;
  logic                 tag_match;
  logic                 suppress;
  logic                 hit;
  logic                 write_enable;

  assign read_index = lookup.pc[btb_depth:1];
  assign read_entry = entry_mem[read_index];
  assign tag_match = read_entry.tag == lookup.pc[xlen-1:btb_depth+1];

  // a flush, a held fetch or a redirect hides the prediction.
  assign suppress = lookup.stall | lookup.clear | resolve.taken;

  // only a branch or jump hint can report a hit.
  assign hit = tag_match & ~suppress & (lookup.is_branch | lookup.is_uncond);

  always_comb begin
    target = '0;
    branch_hit = 1'b0;
    uncond_hit = 1'b0;
    if (hit) begin
      target = read_entry.target;
      branch_hit = lookup.is_branch;
      uncond_hit = lookup.is_uncond;
    end
  end

  // learn taken branches and every unconditional jump.
  assign write_enable = resolve.is_uncond | (resolve.is_branch & resolve.taken);
  assign write_index = resolve.pc[btb_depth:1];

  always_comb begin
    write_entry.tag = resolve.pc[xlen-1:btb_depth+1];
    write_entry.target = resolve.target;
  end

  always_ff @(posedge clock) begin
    if (write_enable) begin
      entry_mem[write_index] <= write_entry;
    end
  end

endmodule

// ==== design/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor #(
  parameter int btb_depth = 6,
  parameter int bht_depth = 8,
  parameter int ras_depth = 3
) (
  input  logic                           clock,
  input  logic                           reset,
  input  bp_fetch_pkg::bp_lookup_t       lookup,
  input  bp_resolve_pkg::bp_resolve_t    resolve,
  output bp_fetch_pkg::bp_prediction_t   prediction
);
  import bp_fetch_pkg::*;

  logic [xlen-1:0] btb_target;
  logic            btb_branch_hit;
  logic            btb_uncond_hit;
  logic            bht_taken;
  logic [xlen-1:0] ras_ret_addr;
  logic            ras_ret_valid;

  bp_target_buffer #(
    .btb_depth (btb_depth)
  ) target_buffer_i (
    .clock      (clock),
    .lookup     (lookup),
    .resolve    (resolve),
    .target     (btb_target),
    .branch_hit (btb_branch_hit),
    .uncond_hit (btb_uncond_hit)
  );

  bp_history_table #(
    .bht_depth (bht_depth)
  ) history_table_i (
    .clock   (clock),
    .reset   (reset),
    .lookup  (lookup),
    .resolve (resolve),
    .taken   (bht_taken)
  );

  bp_return_stack #(
    .ras_depth (ras_depth)
  ) return_stack_i (
    .clock     (clock),
    .reset     (reset),
    .lookup    (lookup),
    .resolve   (resolve),
    .ret_addr  (ras_ret_addr),
    .ret_valid (ras_ret_valid)
  );

  // each unit already applies its own suppression.
  assign prediction = '{
    target:     btb_target,
    branch_hit: btb_branch_hit,
    uncond_hit: btb_uncond_hit,
    taken:      bht_taken,
    ret_addr:   ras_ret_addr,
    ret_valid:  ras_ret_valid
  };

endmodule

// ==== dv/branch_predictor_props.sv ====
`timescale 1ns/1ps

module branch_predictor_props (
  input logic                         clock,
  input logic                         reset,
  input bp_fetch_pkg::bp_lookup_t     lookup,
  input bp_resolve_pkg::bp_resolve_t  resolve,
  input bp_fetch_pkg::bp_prediction_t prediction
);
  int   failures = 0;
  logic quiet;

  assign quiet = lookup.stall | lookup.clear | resolve.taken;

  // nothing is predicted during a stall, a flush or a redirect.
  quiet_no_flags: assert property (@(posedge clock) disable iff (reset)
    quiet |-> !(prediction.branch_hit | prediction.uncond_hit | prediction.taken |
                prediction.ret_valid))
  else begin
    failures++;
    $error("prediction flag high while suppressed");
  end

  ret_needs_hint: assert property (@(posedge clock) disable iff (reset)
    prediction.ret_valid |-> lookup.is_return)
  else begin
    failures++;
    $error("ret_valid without a return hint");
  end

  // a miss drives a zero target.
  miss_zero_target: assert property (@(posedge clock) disable iff (reset)
    !(prediction.branch_hit | prediction.uncond_hit) |-> prediction.target == '0)
  else begin
    failures++;
    $error("nonzero target without a hit");
  end

endmodule

bind branch_predictor branch_predictor_props props_i (
  .clock      (clock),
  .reset      (reset),
  .lookup     (lookup),
  .resolve    (resolve),
  .prediction (prediction)
);

// ==== dv/branch_predictor_tb.sv ====
`timescale 1ns/1ps

module branch_predictor_tb;
  import bp_fetch_pkg::*;
  import bp_resolve_pkg::*;

  localparam int btb_depth = 6;
  localparam int bht_depth = 8;
  localparam int ras_depth = 3;
  localparam int ras_entries = 2 ** ras_depth;
  // reset, then the cycles of each test in order.
  localparam int test_cycles = 2 + 3 + 4 + 50 + 26 + 15;

  logic           clock;
  logic           reset;
  bp_lookup_t     lookup;
  bp_resolve_t    resolve;
  bp_prediction_t prediction;

  // reference models of the three tables.
  logic [xlen-btb_depth-2:0] ref_tag [2 ** btb_depth];
  logic [xlen-1:0]           ref_target [2 ** btb_depth];
  logic [bht_depth-1:0]      ref_history;
  ctr_t                      ref_ctr [2 ** bht_depth];
  logic [xlen-1:0]           ref_stack [ras_entries];
  logic [ras_depth-1:0]      ref_ptr;
  int                        ref_count;

  logic [31:0]     lfsr_state = 32'hf1a8_cae7;
  int              errors = 0;
  int              test_errors = 0;
  int              tests_failed = 0;
  logic [xlen-1:0] jump_pc;
  logic [xlen-1:0] jump_target;
  logic [xlen-1:0] branch_pc;
  logic [xlen-1:0] branch_target;

  branch_predictor branch_predictor_i (
    .clock      (clock),
    .reset      (reset),
    .lookup     (lookup),
    .resolve    (resolve),
    .prediction (prediction)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #50 clock = ~clock;
    end
  end

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] random_bits(input int width);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < width; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // top bit set so that a zero table entry never matches.
  function automatic logic [xlen-1:0] random_pc();
    logic [31:0] bits;
    bits = random_bits(30);
    return {1'b1, bits[29:0], 1'b0};
  endfunction

  function automatic logic [xlen-1:0] random_target();
    logic [31:0] bits;
    bits = random_bits(31);
    return {bits[30:0], 1'b0};
  endfunction

  function automatic bp_prediction_t expected_prediction();
    bp_prediction_t       p;
    logic [btb_depth-1:0] bi;
    logic [bht_depth-1:0] hi;
    logic                 quiet;
    p = '0;
    quiet = lookup.stall | lookup.clear | resolve.taken;
    bi = lookup.pc[btb_depth:1];
    hi = ref_history ^ lookup.pc[bht_depth:1];
    if (!quiet) begin
      if ((lookup.is_branch | lookup.is_uncond) &&
          ref_tag[bi] == lookup.pc[xlen-1:btb_depth+1]) begin
        p.target = ref_target[bi];
        p.branch_hit = lookup.is_branch;
        p.uncond_hit = lookup.is_uncond;
      end
      p.taken = lookup.is_branch & ref_ctr[hi][1];
      if (lookup.is_return && ref_count > 0) begin
        p.ret_valid = 1'b1;
        p.ret_addr = ref_stack[ref_ptr - 1'b1];
      end
    end
    return p;
  endfunction

  task automatic init_models();
    for (int i = 0; i < 2 ** btb_depth; i++) begin
      ref_tag[i] = '0;
      ref_target[i] = '0;
    end
    for (int i = 0; i < 2 ** bht_depth; i++) begin
      ref_ctr[i] = ctr_min;
    end
    for (int i = 0; i < ras_entries; i++) begin
      ref_stack[i] = '0;
    end
    ref_history = '0;
    ref_ptr = '0;
    ref_count = 0;
  endtask

  // applies this cycle's resolution and pop, as the edge will.
  task automatic update_models();
    bp_prediction_t       p;
    logic [bht_depth-1:0] ui;
    p = expected_prediction();
    ui = ref_history ^ resolve.pc[bht_depth:1];
    if (resolve.is_uncond || (resolve.is_branch && resolve.taken)) begin
      ref_tag[resolve.pc[btb_depth:1]] = resolve.pc[xlen-1:btb_depth+1];
      ref_target[resolve.pc[btb_depth:1]] = resolve.target;
    end
    if (resolve.is_branch) begin
      if (resolve.taken && ref_ctr[ui] != ctr_max) begin
        ref_ctr[ui] = ref_ctr[ui] + 2'd1;
      end else if (!resolve.taken && ref_ctr[ui] != ctr_min) begin
        ref_ctr[ui] = ref_ctr[ui] - 2'd1;
      end
      ref_history = {ref_history[bht_depth-2:0], resolve.taken};
    end
    if (resolve.is_call) begin
      ref_stack[ref_ptr] = resolve.next_pc;
      ref_ptr = ref_ptr + 1'b1;
      if (ref_count < ras_entries) begin
        ref_count++;
      end
    end else if (p.ret_valid) begin
      ref_ptr = ref_ptr - 1'b1;
      ref_count--;
    end
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [67:0] expected, input logic [67:0] actual);
    $display("ERR %s %s expected %0h actual %0h", test, what, expected, actual);
    errors++;
    test_errors++;
  endtask

  task automatic finish_test(input string test);
    if (test_errors == 0) begin
      $display("%s: pass", test);
    end else begin
      $display("%s: %0d errors", test, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic idle_inputs();
    lookup = '0;
    resolve = '0;
  endtask

  task automatic check_cycle(input string test);
    bp_prediction_t expected;
    #10;
    expected = expected_prediction();
    if (prediction !== expected) begin
      report_mismatch(test, "prediction", 68'(expected), 68'(prediction));
    end
  endtask

  task automatic advance();
    update_models();
    @(posedge clock);
    #1;
    idle_inputs();
  endtask

  task automatic push_call(input logic [xlen-1:0] ret);
    resolve.pc = random_pc();
    resolve.target = random_target();
    resolve.next_pc = ret;
    resolve.is_call = 1'b1;
    resolve.taken = 1'b1;
  endtask

  task automatic target_learning();
    string name;
    name = "target_learning";
    jump_pc = random_pc();
    jump_target = random_target();
    lookup.pc = jump_pc;
    lookup.is_uncond = 1'b1;
    check_cycle(name);
    if (prediction.uncond_hit !== 1'b0) begin
      report_mismatch(name, "uncond_hit", 68'(1'b0), 68'(prediction.uncond_hit));
    end
    advance();
    resolve.pc = jump_pc;
    resolve.target = jump_target;
    resolve.is_uncond = 1'b1;
    resolve.taken = 1'b1;
    check_cycle(name);
    advance();
    lookup.pc = jump_pc;
    lookup.is_uncond = 1'b1;
    check_cycle(name);
    if (prediction.uncond_hit !== 1'b1 || prediction.target !== jump_target) begin
      report_mismatch(name, "hit,target", 68'({1'b1, jump_target}),
                      68'({prediction.uncond_hit, prediction.target}));
    end
    advance();
    finish_test(name);
  endtask

  task automatic tag_check();
    string name;
    name = "tag_check";
    // same index bits, different tag.
    branch_pc = jump_pc ^ 32'h0010_0000;
    branch_target = random_target();
    lookup.pc = branch_pc;
    lookup.is_branch = 1'b1;
    check_cycle(name);
    if (prediction.branch_hit !== 1'b0) begin
      report_mismatch(name, "branch_hit", 68'(1'b0), 68'(prediction.branch_hit));
    end
    advance();
    resolve.pc = branch_pc;
    resolve.target = branch_target;
    resolve.is_branch = 1'b1;
    resolve.taken = 1'b1;
    check_cycle(name);
    advance();
    lookup.pc = jump_pc;
    lookup.is_uncond = 1'b1;
    check_cycle(name);
    if (prediction.uncond_hit !== 1'b0) begin
      report_mismatch(name, "old uncond_hit", 68'(1'b0), 68'(prediction.uncond_hit));
    end
    advance();
    lookup.pc = branch_pc;
    lookup.is_branch = 1'b1;
    check_cycle(name);
    if (prediction.branch_hit !== 1'b1 || prediction.target !== branch_target) begin
      report_mismatch(name, "hit,target", 68'({1'b1, branch_target}),
                      68'({prediction.branch_hit, prediction.target}));
    end
    advance();
    finish_test(name);
  endtask

  // twelve outcomes fill the history, so the last ones hit one counter.
  task automatic counter_training();
    string           name;
    logic [xlen-1:0] train_pc;
    logic [xlen-1:0] train_target;
    name = "counter_training";
    train_pc = random_pc();
    train_target = random_target();
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < 12; i++) begin
        lookup.pc = train_pc;
        lookup.is_branch = 1'b1;
        check_cycle(name);
        advance();
        resolve.pc = train_pc;
        resolve.target = train_target;
        resolve.is_branch = 1'b1;
        resolve.taken = (round == 0);
        check_cycle(name);
        advance();
      end
      lookup.pc = train_pc;
      lookup.is_branch = 1'b1;
      check_cycle(name);
      if (prediction.taken !== (round == 0)) begin
        report_mismatch(name, "saturated taken", 68'(round == 0), 68'(prediction.taken));
      end
      advance();
    end
    finish_test(name);
  endtask

  task automatic return_lookup(input string test, input logic [xlen-1:0] ret, input logic valid);
    lookup.pc = random_pc();
    lookup.is_return = 1'b1;
    check_cycle(test);
    if (prediction.ret_valid !== valid || (valid && prediction.ret_addr !== ret)) begin
      report_mismatch(test, "ret_valid,ret_addr", 68'({valid, ret}),
                      68'({prediction.ret_valid, prediction.ret_addr}));
    end
    advance();
  endtask

  task automatic return_stack();
    string           name;
    logic [xlen-1:0] pushed [10];
    name = "return_stack";
    for (int i = 0; i < 3; i++) begin
      pushed[i] = random_target();
      push_call(pushed[i]);
      check_cycle(name);
      advance();
    end
    for (int i = 2; i >= 0; i--) begin
      return_lookup(name, pushed[i], 1'b1);
    end
    return_lookup(name, '0, 1'b0);
    for (int i = 0; i < 10; i++) begin
      pushed[i] = random_target();
      push_call(pushed[i]);
      check_cycle(name);
      advance();
    end
    // the two oldest calls were overwritten.
    for (int i = 9; i >= 2; i--) begin
      return_lookup(name, pushed[i], 1'b1);
    end
    return_lookup(name, '0, 1'b0);
    finish_test(name);
  endtask

  task automatic suppression();
    string           name;
    logic [xlen-1:0] ret;
    name = "suppression";
    ret = random_target();
    // taken outcomes fill the history and lift the branch's counter.
    for (int i = 0; i < 10; i++) begin
      resolve.pc = branch_pc;
      resolve.target = branch_target;
      resolve.is_branch = 1'b1;
      resolve.taken = 1'b1;
      check_cycle(name);
      advance();
    end
    push_call(ret);
    check_cycle(name);
    advance();
    // stall, then flush, then a redirect from execute.
    for (int mode = 0; mode < 3; mode++) begin
      lookup.pc = branch_pc;
      lookup.is_branch = 1'b1;
      lookup.is_return = 1'b1;
      lookup.stall = (mode == 0);
      lookup.clear = (mode == 1);
      if (mode == 2) begin
        resolve.pc = branch_pc;
        resolve.target = branch_target;
        resolve.is_branch = 1'b1;
        resolve.taken = 1'b1;
      end
      check_cycle(name);
      if (prediction !== '0) begin
        report_mismatch(name, "suppressed prediction", 68'(0), 68'(prediction));
      end
      advance();
    end
    lookup.pc = branch_pc;
    lookup.is_branch = 1'b1;
    lookup.is_return = 1'b1;
    check_cycle(name);
    if (prediction.branch_hit !== 1'b1 || prediction.taken !== 1'b1 ||
        prediction.ret_valid !== 1'b1 || prediction.ret_addr !== ret) begin
      report_mismatch(name, "hit,taken,ret_valid,ret_addr", 68'({1'b1, 1'b1, 1'b1, ret}),
                      68'({prediction.branch_hit, prediction.taken, prediction.ret_valid,
                           prediction.ret_addr}));
    end
    advance();
    finish_test(name);
  endtask

  initial begin
    #((test_cycles + 50) * 100);
    $display("watchdog: the tests did not finish within %0d cycles", test_cycles + 50);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    idle_inputs();
    reset = 1'b1;
    init_models();
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    target_learning();
    tag_check();
    counter_training();
    return_stack();
    suppression();
    $display("summary: 5 tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_failed, errors, branch_predictor_i.props_i.failures);
    if (errors == 0 && branch_predictor_i.props_i.failures == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
design/bp_fetch_pkg.sv
design/bp_resolve_pkg.sv
design/bp_target_buffer.sv
design/bp_history_table.sv
design/bp_return_stack.sv
design/branch_predictor.sv
dv/branch_predictor_props.sv
dv/branch_predictor_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the branch predictor testbench with verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module branch_predictor_tb -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vbranch_predictor_tb +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1
